/* Bender.yml */
package:
  name: lookup_engine

export_include_dirs:
  - src

sources:
  - src/lookup_pkg.sv
  - src/tcam_match.sv
  - src/action_ram.sv
  - src/action_select.sv
  - src/ctrl_parser.sv
  - src/lookup_engine_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/lookup_engine_tb.sv

/* lookup_engine.f */
+incdir+src
src/lookup_pkg.sv
src/tcam_match.sv
src/action_ram.sv
src/action_select.sv
src/ctrl_parser.sv
src/lookup_engine_top.sv
tests/tb_clock_gen.sv
tests/lookup_engine_tb.sv

/* src/action_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lookup_cfg.svh"

module action_ram (
    input  wire                    clk,
    input  lookup_pkg::act_wr_t    act_wr,
    input  wire [`LE_ADDR_W-1:0]   hit_addr,
    output logic [`LE_ACT_W-1:0]   stored_action
);

    localparam int DEPTH = `LE_DEPTH;
    localparam int ACT_W = `LE_ACT_W;

    logic [ACT_W-1:0] mem_q [DEPTH];

    always_ff @(posedge clk) begin
        if (act_wr.en) begin
            mem_q[act_wr.addr] <= act_wr.action;
        end
    end

    // read every cycle, old data on a same-address write
    always_ff @(posedge clk) begin
        stored_action <= mem_q[hit_addr];
    end

endmodule

`default_nettype wire

/* src/action_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lookup_cfg.svh"

module action_select (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    req_valid,
    input  wire [`LE_PHV_W-1:0]    phv,
    input  wire                    hit,
    input  wire [`LE_ACT_W-1:0]    stored_action,
    output lookup_pkg::lookup_res_t res,
    output logic                   res_valid
);

    localparam int ACT_W = `LE_ACT_W;
    localparam int PHV_W = `LE_PHV_W;
    localparam logic [ACT_W-1:0] DEFAULT_ACT = ACT_W'(`LE_DEFAULT_ACT);

    logic             valid_s1_q;
    logic             valid_s2_q;
    logic             hit_s2_q;
    logic [PHV_W-1:0] phv_s1_q;
    logic [PHV_W-1:0] phv_s2_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1_q <= 1'b0;
            valid_s2_q <= 1'b0;
            hit_s2_q   <= 1'b0;
        end else begin
            valid_s1_q <= req_valid;
            valid_s2_q <= valid_s1_q;
            // hit is already one stage in
            hit_s2_q   <= hit;
        end
    end

    always_ff @(posedge clk) begin
        phv_s1_q <= phv;
        phv_s2_q <= phv_s1_q;
    end

    assign res_valid = valid_s2_q;
    assign res = '{action: hit_s2_q ? stored_action : DEFAULT_ACT, phv: phv_s2_q};

endmodule

`default_nettype wire

/* src/ctrl_parser.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lookup_cfg.svh"

module ctrl_parser #(
    parameter logic [4:0] stage_id  = 5'd0,
    parameter logic [2:0] lookup_id = 3'd0
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  lookup_pkg::ctrl_beat_t ctrl_in,
    output lookup_pkg::ctrl_beat_t ctrl_out,
    output lookup_pkg::cam_wr_t    cam_wr,
    output lookup_pkg::act_wr_t    act_wr
);

    localparam int CTRL_W = `LE_CTRL_W;
    localparam int ACT_W  = `LE_ACT_W;
    localparam int KEY_W  = `LE_KEY_W;
    localparam int ADDR_W = `LE_ADDR_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_TABLE,
        ST_ACTION,
        ST_FWD
    } state_t;

    state_t              state_q;
    logic [ADDR_W-1:0]   idx_q;
    logic                cam_en_q;
    logic                act_en_q;
    logic [ADDR_W-1:0]   wr_addr_q;
    logic [ACT_W-1:0]    wr_data_q;
    logic                fwd_valid_q;
    logic                fwd_last_q;
    logic [CTRL_W-1:0]   fwd_data_q;
    logic [CTRL_W-1:0]   swapped;
    logic [15:0]         flag;
    logic [7:0]          mod_id;
    logic [3:0]          resv;
    logic                for_us;

    assign flag   = ctrl_in.data[`LE_FLAG_LSB +: 16];
    assign mod_id = ctrl_in.data[`LE_MODID_LSB +: 8];
    assign resv   = ctrl_in.data[`LE_RESV_LSB +: 4];
    assign for_us = (flag == `LE_CTRL_FLAG) && (mod_id[7:3] == stage_id) &&
                    (mod_id[2:0] == lookup_id);

    // entries arrive little endian
    always_comb begin
        for (int i = 0; i < CTRL_W / 8; i++) begin
            swapped[8*i +: 8] = ctrl_in.data[CTRL_W-8-8*i +: 8];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= ST_IDLE;
            idx_q       <= '0;
            cam_en_q    <= 1'b0;
            act_en_q    <= 1'b0;
            fwd_valid_q <= 1'b0;
        end else begin
            cam_en_q    <= 1'b0;
            act_en_q    <= 1'b0;
            fwd_valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (ctrl_in.valid && for_us) begin
                        idx_q <= ctrl_in.data[`LE_INDEX_LSB +: ADDR_W];
                        if (!ctrl_in.last) begin
                            state_q <= (resv == 4'd0) ? ST_TABLE : ST_ACTION;
                        end
                    end else if (ctrl_in.valid) begin
                        fwd_valid_q <= 1'b1;
                        if (!ctrl_in.last) begin
                            state_q <= ST_FWD;
                        end
                    end
                end
                ST_TABLE, ST_ACTION: begin
                    if (ctrl_in.valid) begin
                        cam_en_q <= (state_q == ST_TABLE);
                        act_en_q <= (state_q == ST_ACTION);
                        idx_q    <= idx_q + 1'b1;
                        if (ctrl_in.last) begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
                ST_FWD: begin
                    fwd_valid_q <= ctrl_in.valid;
                    if (ctrl_in.valid && ctrl_in.last) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // payload, qualified by the enables above
    always_ff @(posedge clk) begin
        fwd_data_q <= ctrl_in.data;
        fwd_last_q <= ctrl_in.last;
        wr_addr_q  <= idx_q;
        wr_data_q  <= swapped[CTRL_W-1 -: ACT_W];
    end

    assign ctrl_out = '{data: fwd_data_q, valid: fwd_valid_q, last: fwd_last_q};
    assign cam_wr   = '{en: cam_en_q, addr: wr_addr_q, entry: wr_data_q[ACT_W-1 -: KEY_W]};
    assign act_wr   = '{en: act_en_q, addr: wr_addr_q, action: wr_data_q};

endmodule

`default_nettype wire

/* src/lookup_cfg.svh */
`ifndef LOOKUP_CFG_SVH
`define LOOKUP_CFG_SVH

// datapath widths
`define LE_CTRL_W      128
`define LE_KEY_W       48
`define LE_ACT_W       64
`define LE_PHV_W       128

// table geometry
`define LE_DEPTH       16
`define LE_ADDR_W      4

// header fields in the raw first beat
`define LE_FLAG_LSB    64
`define LE_INDEX_LSB   96
`define LE_MODID_LSB   112
`define LE_RESV_LSB    120

// configuration packet marker, udp dst port
`define LE_CTRL_FLAG   16'hf2f1

// returned on a table miss
`define LE_DEFAULT_ACT 8'h3f

`endif

/* src/lookup_engine_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lookup_cfg.svh"

module lookup_engine_top #(
    parameter logic [4:0] stage_id  = 5'd0,
    parameter logic [2:0] lookup_id = 3'd0
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  lookup_pkg::ctrl_beat_t  ctrl_in,
    output lookup_pkg::ctrl_beat_t  ctrl_out,
    input  lookup_pkg::lookup_req_t req,
    input  wire                     req_valid,
    output lookup_pkg::lookup_res_t res,
    output logic                    res_valid
);

    lookup_pkg::cam_wr_t    cam_wr;
    lookup_pkg::act_wr_t    act_wr;
    logic                   hit;
    logic [`LE_ADDR_W-1:0]  hit_addr;
    logic [`LE_ACT_W-1:0]   stored_action;

    // control path
    ctrl_parser #(
        .stage_id  (stage_id),
        .lookup_id (lookup_id)
    ) parser_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl_in  (ctrl_in),
        .ctrl_out (ctrl_out),
        .cam_wr   (cam_wr),
        .act_wr   (act_wr)
    );

    // lookup path
    tcam_match tcam_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cam_wr   (cam_wr),
        .key      (req.key),
        .mask     (req.mask),
        .hit      (hit),
        .hit_addr (hit_addr)
    );

    action_ram ram_i (
        .clk           (clk),
        .act_wr        (act_wr),
        .hit_addr      (hit_addr),
        .stored_action (stored_action)
    );

    action_select select_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .phv           (req.phv),
        .hit           (hit),
        .stored_action (stored_action),
        .res           (res),
        .res_valid     (res_valid)
    );

endmodule

`default_nettype wire

/* src/lookup_pkg.sv */
`default_nettype none

`include "lookup_cfg.svh"

package lookup_pkg;

    // one beat of the control stream
    typedef struct packed {
        logic [`LE_CTRL_W-1:0] data;
        logic                  valid;
        logic                  last;
    } ctrl_beat_t;

    // lookup request from the key extractor
    typedef struct packed {
        logic [`LE_KEY_W-1:0] key;
        logic [`LE_KEY_W-1:0] mask;
        logic [`LE_PHV_W-1:0] phv;
    } lookup_req_t;

    // lookup result to the action engine
    typedef struct packed {
        logic [`LE_ACT_W-1:0] action;
        logic [`LE_PHV_W-1:0] phv;
    } lookup_res_t;

    // match table write
    typedef struct packed {
        logic                  en;
        logic [`LE_ADDR_W-1:0] addr;
        logic [`LE_KEY_W-1:0]  entry;
    } cam_wr_t;

    // action memory write
    typedef struct packed {
        logic                  en;
        logic [`LE_ADDR_W-1:0] addr;
        logic [`LE_ACT_W-1:0]  action;
    } act_wr_t;

endpackage

`default_nettype wire

/* src/tcam_match.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lookup_cfg.svh"

module tcam_match (
    input  wire                    clk,
    input  wire                    rst_n,
    input  lookup_pkg::cam_wr_t    cam_wr,
    input  wire [`LE_KEY_W-1:0]    key,
    input  wire [`LE_KEY_W-1:0]    mask,
    output logic                   hit,
    output logic [`LE_ADDR_W-1:0]  hit_addr
);

    localparam int DEPTH  = `LE_DEPTH;
    localparam int KEY_W  = `LE_KEY_W;
    localparam int ADDR_W = `LE_ADDR_W;

    logic [KEY_W-1:0]  entry_q [DEPTH];
    logic [DEPTH-1:0]  match_vec;
    logic              hit_d;
    logic [ADDR_W-1:0] addr_d;

    // empty table is all ones
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                entry_q[i] <= '1;
            end
        end else if (cam_wr.en) begin
            entry_q[cam_wr.addr] <= cam_wr.entry;
        end
    end

    // mask bit set means don't care
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            match_vec[i] = ((entry_q[i] ^ key) & ~mask) == '0;
        end
    end

    // walk down so the lowest index wins
    always_comb begin
        hit_d  = 1'b0;
        addr_d = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                hit_d  = 1'b1;
                addr_d = ADDR_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit      <= 1'b0;
            hit_addr <= '0;
        end else begin
            hit      <= hit_d;
            hit_addr <= addr_d;
        end
    end

endmodule

`default_nettype wire

/* tests/lookup_engine_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lookup_cfg.svh"

module lookup_engine_tb;

    localparam int WORDS   = 256;
    localparam int TIMEOUT = 20;

    logic                    clk;
    logic                    rst_n;
    lookup_pkg::ctrl_beat_t  ctrl_in;
    lookup_pkg::ctrl_beat_t  ctrl_out;
    lookup_pkg::lookup_req_t req;
    logic                    req_valid;
    lookup_pkg::lookup_res_t res;
    logic                    res_valid;

    logic [127:0]            pat [WORDS];
    lookup_pkg::ctrl_beat_t  fwd_q [$];
    lookup_pkg::lookup_res_t res_q [$];
    int                      res_cyc_q [$];
    int                      req_cyc_q [$];
    int                      cyc = 0;
    int                      errors = 0;
    int                      n_pass = 0;
    int                      n_fail = 0;

    tb_clock_gen #(
        .period_ns    (8),
        .reset_cycles (2)
    ) clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    lookup_engine_top #(
        .stage_id  (5'd1),
        .lookup_id (3'd2)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl_in   (ctrl_in),
        .ctrl_out  (ctrl_out),
        .req       (req),
        .req_valid (req_valid),
        .res       (res),
        .res_valid (res_valid)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // outputs are registered, so mid-cycle they are settled
    always @(negedge clk) begin
        if (ctrl_out.valid) begin
            fwd_q.push_back(ctrl_out);
        end
        if (res_valid) begin
            res_q.push_back(res);
            // stamped with the edge that samples it
            res_cyc_q.push_back(cyc + 1);
        end
    end

    function automatic string test_name(input int t);
        case (t)
            1: return "foreign packets forwarded";
            2: return "table and action write";
            3: return "miss returns default";
            4: return "masked match and priority";
            5: return "multi-entry packets";
            6: return "other lookup id ignored";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_test(input int t);
        if (errors == 0) begin
            $display("test %0d %s: pass", t, test_name(t));
            n_pass++;
        end else begin
            $display("test %0d %s: %0d errors", t, test_name(t), errors);
            n_fail++;
        end
        errors = 0;
    endtask

    initial begin
        int                      p;
        int                      cur_test;
        int                      waited;
        int                      got_cyc;
        int                      sent_cyc;
        logic [3:0]              op;
        lookup_pkg::ctrl_beat_t  beat;
        lookup_pkg::lookup_res_t got;

        ctrl_in   = '0;
        req       = '0;
        req_valid = 1'b0;
        $readmemh("tests/lookup_patterns.hex", pat);

        waited = 0;
        while (rst_n !== 1'b1 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            n_fail++;
        end
        @(negedge clk);

        p = 0;
        cur_test = pat[1];
        while (p + 5 <= WORDS && pat[p][3:0] != 4'd0) begin
            op = pat[p][3:0];
            if (pat[p+1] != cur_test) begin
                report_test(cur_test);
                cur_test = pat[p+1];
            end
            case (op)
                4'd1: begin
                    ctrl_in.data  = pat[p+2];
                    ctrl_in.last  = pat[p+3][0];
                    ctrl_in.valid = 1'b1;
                    @(negedge clk);
                    ctrl_in.valid = 1'b0;
                end
                4'd2: begin
                    req.key   = pat[p+2][`LE_KEY_W-1:0];
                    req.mask  = pat[p+3][`LE_KEY_W-1:0];
                    req.phv   = pat[p+4];
                    req_valid = 1'b1;
                    req_cyc_q.push_back(cyc + 1);
                    @(negedge clk);
                    req_valid = 1'b0;
                end
                4'd3: begin
                    waited = 0;
                    while (fwd_q.size() == 0 && waited < TIMEOUT) begin
                        @(negedge clk);
                        waited++;
                    end
                    if (fwd_q.size() == 0) begin
                        $display("%s: no forwarded beat came out in time", test_name(cur_test));
                        errors++;
                    end else begin
                        beat = fwd_q.pop_front();
                        if (beat.data !== pat[p+2] || beat.last !== pat[p+3][0]) begin
                            $display("FAIL %s expected %h last %0d actual %h last %0d",
                                     test_name(cur_test), pat[p+2], pat[p+3][0],
                                     beat.data, beat.last);
                            errors++;
                        end
                    end
                end
                4'd4: begin
                    waited = 0;
                    while (res_q.size() == 0 && waited < TIMEOUT) begin
                        @(negedge clk);
                        waited++;
                    end
                    if (res_q.size() == 0) begin
                        $display("%s: no lookup result came out in time", test_name(cur_test));
                        errors++;
                    end else begin
                        got      = res_q.pop_front();
                        got_cyc  = res_cyc_q.pop_front();
                        sent_cyc = (req_cyc_q.size() > 0) ? req_cyc_q.pop_front() : -100;
                        if (got.action !== pat[p+2][`LE_ACT_W-1:0] || got.phv !== pat[p+3]) begin
                            $display("FAIL %s expected %h %h actual %h %h",
                                     test_name(cur_test), pat[p+2][`LE_ACT_W-1:0], pat[p+3],
                                     got.action, got.phv);
                            errors++;
                        end
                        if (got_cyc - sent_cyc != 2) begin
                            $display("FAIL %s latency expected 2 actual %0d",
                                     test_name(cur_test), got_cyc - sent_cyc);
                            errors++;
                        end
                    end
                end
                4'd5: begin
                    repeat (pat[p+2][7:0]) @(negedge clk);
                end
                default: begin
                    $display("pattern file holds an unknown opcode %0h", op);
                    errors++;
                end
            endcase
            p += 5;
        end

        // nothing may come out that no record expected
        repeat (4) @(negedge clk);
        if (fwd_q.size() != 0 || res_q.size() != 0) begin
            $display("unexpected output: %0d forwarded beats and %0d results left over",
                     fwd_q.size(), res_q.size());
            errors++;
        end
        report_test(cur_test);

        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/lookup_patterns.hex */
// op test f1 f2 f3: 1 ctrl beat (data last), 2 lookup (key mask phv), 3 expect forward
// (data last), 4 expect result (action phv), 5 idle (cycles), 0 end of patterns
1 01 000a00030000f2f00000000000000000 0 0
1 01 0123456789abcdef0123456789abcdef 1 0
1 01 001200000000f2f10000000000000000 1 0
3 01 000a00030000f2f00000000000000000 0 0
3 01 0123456789abcdef0123456789abcdef 1 0
3 01 001200000000f2f10000000000000000 1 0
1 02 000a00030000f2f10000000000000000 0 0
1 02 deadbeefdeadbeef0000ffeeddccbbaa 1 0
1 02 010a00030000f2f10000000000000000 0 0
1 02 deadbeefdeadbeef8877665544332211 1 0
5 02 2 0 0
2 02 aabbccddeeff 000000000000 a5a5a5a5000000000000000000000201
4 02 1122334455667788 a5a5a5a5000000000000000000000201 0
2 03 123456789abc 000000000000 a5a5a5a5000000000000000000000301
4 03 000000000000003f a5a5a5a5000000000000000000000301 0
1 04 000a00050000f2f10000000000000000 0 0
1 04 00000000000000000000a00000005555 0 0
1 04 00000000000000000000b00000005555 1 0
1 04 010a00050000f2f10000000000000000 0 0
1 04 0000000000000000050000000000a5a5 0 0
1 04 0000000000000000060000000000a6a6 1 0
5 04 2 0 0
2 04 5555000000b7 000000000007 a5a5a5a5000000000000000000000401
2 04 5555000000a0 0000000000f0 a5a5a5a5000000000000000000000402
4 04 a6a6000000000006 a5a5a5a5000000000000000000000401 0
4 04 a5a5000000000005 a5a5a5a5000000000000000000000402 0
1 05 000a00080000f2f10000000000000000 0 0
1 05 00000000000000000000080000000010 0 0
1 05 00000000000000000000090000000010 0 0
1 05 000000000000000000000a0000000010 1 0
1 05 010a00080000f2f10000000000000000 0 0
1 05 00000000000000000800000000000080 0 0
1 05 00000000000000000900000000000090 0 0
1 05 00000000000000000a000000000000a0 1 0
5 05 2 0 0
2 05 100000000008 000000000000 a5a5a5a5000000000000000000000501
2 05 100000000009 000000000000 a5a5a5a5000000000000000000000502
2 05 10000000000a 000000000000 a5a5a5a5000000000000000000000503
4 05 8000000000000008 a5a5a5a5000000000000000000000501 0
4 05 9000000000000009 a5a5a5a5000000000000000000000502 0
4 05 a00000000000000a a5a5a5a5000000000000000000000503 0
1 06 000b00030000f2f10000000000000000 0 0
1 06 00000000000000000000777777777777 1 0
3 06 000b00030000f2f10000000000000000 0 0
3 06 00000000000000000000777777777777 1 0
2 06 aabbccddeeff 000000000000 a5a5a5a5000000000000000000000601
4 06 1122334455667788 a5a5a5a5000000000000000000000601 0
0 00 0 0 0

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

    // released on a falling edge
    initial begin
        rst_n = 1'b0;
        #(period_ns * reset_cycles);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
